// ==== source/zcash_shell_pkg.sv ====
`default_nettype none

package zcash_shell_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int WORD_W = 64;

  typedef logic [ADDR_W-1:0]   axil_addr_t;
  typedef logic [DATA_W-1:0]   axil_data_t;
  typedef logic [DATA_W/8-1:0] axil_strb_t;
  typedef logic [1:0]          axil_resp_t;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [15:0]         count_t;

  // AXI-lite response codes
  localparam axil_resp_t RESP_OKAY   = 2'd0;
  localparam axil_resp_t RESP_SLVERR = 2'd2;
  localparam axil_resp_t RESP_DECERR = 2'd3;

  // --------------------
  // Register map
  // --------------------
  localparam axil_addr_t REG_DATA_LO = 32'h0000_0000;
  localparam axil_addr_t REG_DATA_HI = 32'h0000_0004;
  // Write data bit 0 marks the last word of a message
  localparam axil_addr_t REG_PUSH    = 32'h0000_0008;
  // Bit 0 result valid, bit 1 core ready
  localparam axil_addr_t REG_STATUS  = 32'h0000_000C;
  localparam axil_addr_t REG_SUM_LO  = 32'h0000_0010;
  localparam axil_addr_t REG_SUM_HI  = 32'h0000_0014;
  localparam axil_addr_t REG_COUNT   = 32'h0000_0018;
  localparam axil_addr_t REG_ACK     = 32'h0000_001C;

endpackage

`default_nettype wire

// ==== source/axi_skid.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_skid #(
  parameter type T = logic
) (
  input  wire logic i_clk_100,
  input  wire logic i_rst_n,

  // Source side
  input  wire logic i_valid,
  input  wire T     i_data,
  output logic      o_ready,

  // Sink side
  output logic      o_valid,
  output T          o_data,
  input  wire logic i_ready
);

  logic valid_q;
  T     data_q;

  // Entry accepts when empty or when the sink drains it this cycle
  assign o_ready = !valid_q || i_ready;

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge i_clk_100) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

`default_nettype wire

// ==== source/axil_reg_slice.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_reg_slice import zcash_shell_pkg::*; (
  input  wire logic       i_clk_100,
  input  wire logic       i_rst_n,

  // Host side
  input  wire logic       i_s_awvalid,
  input  wire axil_addr_t i_s_awaddr,
  output logic            o_s_awready,
  input  wire logic       i_s_wvalid,
  input  wire axil_data_t i_s_wdata,
  input  wire axil_strb_t i_s_wstrb,
  output logic            o_s_wready,
  output logic            o_s_bvalid,
  output axil_resp_t      o_s_bresp,
  input  wire logic       i_s_bready,
  input  wire logic       i_s_arvalid,
  input  wire axil_addr_t i_s_araddr,
  output logic            o_s_arready,
  output logic            o_s_rvalid,
  output axil_data_t      o_s_rdata,
  output axil_resp_t      o_s_rresp,
  input  wire logic       i_s_rready,

  // Register block side
  output logic            o_m_awvalid,
  output axil_addr_t      o_m_awaddr,
  input  wire logic       i_m_awready,
  output logic            o_m_wvalid,
  output axil_data_t      o_m_wdata,
  output axil_strb_t      o_m_wstrb,
  input  wire logic       i_m_wready,
  input  wire logic       i_m_bvalid,
  input  wire axil_resp_t i_m_bresp,
  output logic            o_m_bready,
  output logic            o_m_arvalid,
  output axil_addr_t      o_m_araddr,
  input  wire logic       i_m_arready,
  input  wire logic       i_m_rvalid,
  input  wire axil_data_t i_m_rdata,
  input  wire axil_resp_t i_m_rresp,
  output logic            o_m_rready
);

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } w_beat_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } r_beat_t;

  w_beat_t w_in, w_out;
  r_beat_t r_in, r_out;

  assign w_in.data  = i_s_wdata;
  assign w_in.strb  = i_s_wstrb;
  assign o_m_wdata  = w_out.data;
  assign o_m_wstrb  = w_out.strb;

  assign r_in.data  = i_m_rdata;
  assign r_in.resp  = i_m_rresp;
  assign o_s_rdata  = r_out.data;
  assign o_s_rresp  = r_out.resp;

  // --------------------
  // Request channels
  // --------------------
  axi_skid #(.T(axil_addr_t)) aw_skid (
    .i_clk_100 (i_clk_100),   .i_rst_n (i_rst_n),
    .i_valid   (i_s_awvalid), .i_data  (i_s_awaddr), .o_ready (o_s_awready),
    .o_valid   (o_m_awvalid), .o_data  (o_m_awaddr), .i_ready (i_m_awready)
  );

  axi_skid #(.T(w_beat_t)) w_skid (
    .i_clk_100 (i_clk_100),  .i_rst_n (i_rst_n),
    .i_valid   (i_s_wvalid), .i_data  (w_in),  .o_ready (o_s_wready),
    .o_valid   (o_m_wvalid), .o_data  (w_out), .i_ready (i_m_wready)
  );

  axi_skid #(.T(axil_addr_t)) ar_skid (
    .i_clk_100 (i_clk_100),   .i_rst_n (i_rst_n),
    .i_valid   (i_s_arvalid), .i_data  (i_s_araddr), .o_ready (o_s_arready),
    .o_valid   (o_m_arvalid), .o_data  (o_m_araddr), .i_ready (i_m_arready)
  );

  // --------------------
  // Response channels
  // --------------------
  axi_skid #(.T(axil_resp_t)) b_skid (
    .i_clk_100 (i_clk_100),  .i_rst_n (i_rst_n),
    .i_valid   (i_m_bvalid), .i_data  (i_m_bresp), .o_ready (o_m_bready),
    .o_valid   (o_s_bvalid), .o_data  (o_s_bresp), .i_ready (i_s_bready)
  );

  axi_skid #(.T(r_beat_t)) r_skid (
    .i_clk_100 (i_clk_100),  .i_rst_n (i_rst_n),
    .i_valid   (i_m_rvalid), .i_data  (r_in),  .o_ready (o_m_rready),
    .o_valid   (o_s_rvalid), .o_data  (r_out), .i_ready (i_s_rready)
  );

endmodule

`default_nettype wire

// ==== source/zcash_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module zcash_bridge import zcash_shell_pkg::*; (
  input  wire logic       i_clk_100,
  input  wire logic       i_rst_n,

  // AXI-lite slave
  input  wire logic       i_awvalid,
  input  wire axil_addr_t i_awaddr,
  output logic            o_awready,
  input  wire logic       i_wvalid,
  input  wire axil_data_t i_wdata,
  input  wire axil_strb_t i_wstrb,
  output logic            o_wready,
  output logic            o_bvalid,
  output axil_resp_t      o_bresp,
  input  wire logic       i_bready,
  input  wire logic       i_arvalid,
  input  wire axil_addr_t i_araddr,
  output logic            o_arready,
  output logic            o_rvalid,
  output axil_data_t      o_rdata,
  output axil_resp_t      o_rresp,
  input  wire logic       i_rready,

  // Word stream to the core
  output logic            o_word_valid,
  output word_t           o_word,
  output logic            o_word_last,
  input  wire logic       i_word_ready,

  // Result from the core
  input  wire logic       i_res_valid,
  input  wire word_t      i_res_sum,
  input  wire count_t     i_res_count,
  output logic            o_res_ack
);

  logic       bvalid_q, rvalid_q, word_valid_q, res_ack_q, word_last_q;
  axil_resp_t bresp_q, rresp_q, wr_resp, rd_resp;
  axil_data_t rdata_q, rd_data, data_lo_q, data_hi_q;
  word_t      word_q;
  logic       wr_take, rd_take, push_ok, push_req, ack_req;

  function automatic axil_data_t merge_strb(axil_data_t old_v, axil_data_t new_v,
                                            axil_strb_t strb);
    axil_data_t res;
    res = old_v;
    for (int i = 0; i < DATA_W / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Address and data are taken together, one response outstanding
  assign wr_take   = i_awvalid && i_wvalid && !bvalid_q;
  assign o_awready = wr_take;
  assign o_wready  = wr_take;
  assign rd_take   = i_arvalid && !rvalid_q;
  assign o_arready = !rvalid_q;

  // Core can take a new word only when nothing is still pending here
  assign push_ok = i_word_ready && !word_valid_q;

  // --------------------
  // Write decode
  // --------------------
  always_comb begin
    wr_resp  = RESP_OKAY;
    push_req = 1'b0;
    ack_req  = 1'b0;
    case (i_awaddr)
      REG_DATA_LO, REG_DATA_HI, REG_STATUS,
      REG_SUM_LO, REG_SUM_HI, REG_COUNT: wr_resp = RESP_OKAY;
      REG_PUSH: begin
        if (push_ok) begin
          push_req = 1'b1;
        end else begin
          wr_resp = RESP_SLVERR;
        end
      end
      REG_ACK: ack_req = 1'b1;
      default: wr_resp = RESP_DECERR;
    endcase
  end

  // --------------------
  // Read decode
  // --------------------
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (i_araddr)
      REG_DATA_LO: rd_data = data_lo_q;
      REG_DATA_HI: rd_data = data_hi_q;
      REG_PUSH, REG_ACK: rd_data = '0;
      REG_STATUS: rd_data = {{(DATA_W-2){1'b0}}, push_ok, i_res_valid};
      REG_SUM_LO: rd_data = i_res_sum[DATA_W-1:0];
      REG_SUM_HI: rd_data = i_res_sum[WORD_W-1:DATA_W];
      REG_COUNT: rd_data = axil_data_t'(i_res_count);
      default: rd_resp = RESP_DECERR;
    endcase
  end

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
      word_valid_q <= 1'b0;
      res_ack_q    <= 1'b0;
    end else begin
      // Ack with no result held is dropped here
      res_ack_q <= wr_take && ack_req && i_res_valid;
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_take && push_req) begin
        word_valid_q <= 1'b1;
      end else if (i_word_ready) begin
        word_valid_q <= 1'b0;
      end
      if (rd_take) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (wr_take) begin
      bresp_q <= wr_resp;
      if (i_awaddr == REG_DATA_LO) begin
        data_lo_q <= merge_strb(data_lo_q, i_wdata, i_wstrb);
      end
      if (i_awaddr == REG_DATA_HI) begin
        data_hi_q <= merge_strb(data_hi_q, i_wdata, i_wstrb);
      end
      if (push_req) begin
        word_q      <= {data_hi_q, data_lo_q};
        word_last_q <= i_wdata[0];
      end
    end
    if (rd_take) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign o_bvalid     = bvalid_q;
  assign o_bresp      = bresp_q;
  assign o_rvalid     = rvalid_q;
  assign o_rdata      = rdata_q;
  assign o_rresp      = rresp_q;
  assign o_word_valid = word_valid_q;
  assign o_word       = word_q;
  assign o_word_last  = word_last_q;
  assign o_res_ack    = res_ack_q;

endmodule

`default_nettype wire

// ==== source/zcash_digest_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module zcash_digest_core import zcash_shell_pkg::*; (
  input  wire logic   i_clk_100,
  input  wire logic   i_rst_n,

  // Message words
  input  wire logic   i_word_valid,
  input  wire word_t  i_word,
  input  wire logic   i_word_last,
  output logic        o_word_ready,

  // Result, held until acknowledged
  output logic        o_res_valid,
  output word_t       o_res_sum,
  output count_t      o_res_count,
  input  wire logic   i_res_ack
);

  word_t  acc_q, res_sum_q, acc_next;
  count_t cnt_q, res_cnt_q, cnt_next;
  logic   res_valid_q;
  logic   word_fire;

  // Stall the stream while a result is waiting for the host
  assign o_word_ready = !res_valid_q;
  assign word_fire    = i_word_valid && o_word_ready;

  // Sum wraps modulo 2^64
  assign acc_next = acc_q + i_word;
  assign cnt_next = cnt_q + count_t'(1);

  // --------------------
  // Accumulator
  // --------------------
  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      acc_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else if (word_fire) begin
      if (i_word_last) begin
        // Next message starts from zero
        acc_q       <= '0;
        cnt_q       <= '0;
        res_valid_q <= 1'b1;
      end else begin
        acc_q <= acc_next;
        cnt_q <= cnt_next;
      end
    end else if (i_res_ack) begin
      res_valid_q <= 1'b0;
    end
  end

  // Result capture on the last word
  always_ff @(posedge i_clk_100) begin
    if (word_fire && i_word_last) begin
      res_sum_q <= acc_next;
      res_cnt_q <= cnt_next;
    end
  end

  assign o_res_valid = res_valid_q;
  assign o_res_sum   = res_sum_q;
  assign o_res_count = res_cnt_q;

endmodule

`default_nettype wire

// ==== source/cl_zcash.sv ====
`timescale 1ns/10ps
`default_nettype none

module cl_zcash import zcash_shell_pkg::*; (
  input  wire logic       i_clk_100,
  input  wire logic       i_rst_main_n,

  // Host register port
  input  wire logic       i_awvalid,
  input  wire axil_addr_t i_awaddr,
  output logic            o_awready,
  input  wire logic       i_wvalid,
  input  wire axil_data_t i_wdata,
  input  wire axil_strb_t i_wstrb,
  output logic            o_wready,
  output logic            o_bvalid,
  output axil_resp_t      o_bresp,
  input  wire logic       i_bready,
  input  wire logic       i_arvalid,
  input  wire axil_addr_t i_araddr,
  output logic            o_arready,
  output logic            o_rvalid,
  output axil_data_t      o_rdata,
  output axil_resp_t      o_rresp,
  input  wire logic       i_rready
);

  // --------------------
  // Reset synchronizer
  // --------------------
  logic [1:0] rst_sync_q;
  logic       rst_main_n_sync;

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_main_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  // Assert straight away, release after two flops
  assign rst_main_n_sync = i_rst_main_n && rst_sync_q[1];

  logic       m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic       m_arvalid, m_arready, m_rvalid, m_rready;
  axil_addr_t m_awaddr, m_araddr;
  axil_data_t m_wdata, m_rdata;
  axil_strb_t m_wstrb;
  axil_resp_t m_bresp, m_rresp;

  logic   word_valid, word_last, word_ready;
  word_t  word;
  logic   res_valid, res_ack;
  word_t  res_sum;
  count_t res_count;

  axil_reg_slice axil_reg_slice (
    .i_clk_100   (i_clk_100), .i_rst_n     (rst_main_n_sync),
    .i_s_awvalid (i_awvalid), .i_s_awaddr  (i_awaddr), .o_s_awready (o_awready),
    .i_s_wvalid  (i_wvalid),  .i_s_wdata   (i_wdata),  .i_s_wstrb   (i_wstrb),
    .o_s_wready  (o_wready),
    .o_s_bvalid  (o_bvalid),  .o_s_bresp   (o_bresp),  .i_s_bready  (i_bready),
    .i_s_arvalid (i_arvalid), .i_s_araddr  (i_araddr), .o_s_arready (o_arready),
    .o_s_rvalid  (o_rvalid),  .o_s_rdata   (o_rdata),  .o_s_rresp   (o_rresp),
    .i_s_rready  (i_rready),
    .o_m_awvalid (m_awvalid), .o_m_awaddr  (m_awaddr), .i_m_awready (m_awready),
    .o_m_wvalid  (m_wvalid),  .o_m_wdata   (m_wdata),  .o_m_wstrb   (m_wstrb),
    .i_m_wready  (m_wready),
    .i_m_bvalid  (m_bvalid),  .i_m_bresp   (m_bresp),  .o_m_bready  (m_bready),
    .o_m_arvalid (m_arvalid), .o_m_araddr  (m_araddr), .i_m_arready (m_arready),
    .i_m_rvalid  (m_rvalid),  .i_m_rdata   (m_rdata),  .i_m_rresp   (m_rresp),
    .o_m_rready  (m_rready)
  );

  zcash_bridge zcash_bridge (
    .i_clk_100    (i_clk_100),  .i_rst_n     (rst_main_n_sync),
    .i_awvalid    (m_awvalid),  .i_awaddr    (m_awaddr), .o_awready (m_awready),
    .i_wvalid     (m_wvalid),   .i_wdata     (m_wdata),  .i_wstrb   (m_wstrb),
    .o_wready     (m_wready),
    .o_bvalid     (m_bvalid),   .o_bresp     (m_bresp),  .i_bready  (m_bready),
    .i_arvalid    (m_arvalid),  .i_araddr    (m_araddr), .o_arready (m_arready),
    .o_rvalid     (m_rvalid),   .o_rdata     (m_rdata),  .o_rresp   (m_rresp),
    .i_rready     (m_rready),
    .o_word_valid (word_valid), .o_word      (word),     .o_word_last (word_last),
    .i_word_ready (word_ready),
    .i_res_valid  (res_valid),  .i_res_sum   (res_sum),  .i_res_count (res_count),
    .o_res_ack    (res_ack)
  );

  zcash_digest_core zcash_digest_core (
    .i_clk_100    (i_clk_100),  .i_rst_n     (rst_main_n_sync),
    .i_word_valid (word_valid), .i_word      (word),     .i_word_last (word_last),
    .o_word_ready (word_ready),
    .o_res_valid  (res_valid),  .o_res_sum   (res_sum),  .o_res_count (res_count),
    .i_res_ack    (res_ack)
  );

endmodule

`default_nettype wire

// ==== verif/cl_zcash_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module cl_zcash_properties import zcash_shell_pkg::*; (
  input wire logic       i_clk_100,
  input wire logic       i_rst_n,
  input wire logic       i_bvalid,
  input wire axil_resp_t i_bresp,
  input wire logic       i_bready,
  input wire logic       i_rvalid,
  input wire axil_data_t i_rdata,
  input wire logic       i_rready,
  input wire logic       i_word_ready,
  input wire logic       i_res_valid,
  input wire logic       i_res_ack
);

  int fail_cnt = 0;

  // --------------------
  // Host responses hold until taken
  // --------------------
  bvalid_hold: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      fail_cnt++;
    end

  rvalid_hold: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else begin
      $error("rvalid dropped or rdata changed before rready");
      fail_cnt++;
    end

  // Core stays stalled until the host acknowledges the result
  ready_while_held: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    i_res_valid && !i_res_ack |=> i_res_valid && !i_word_ready)
    else begin
      $error("result released or word ready high without an ack");
      fail_cnt++;
    end

  // Words are taken again the cycle after the ack
  ready_after_ack: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    i_res_valid && i_res_ack |=> !i_res_valid && i_word_ready)
    else begin
      $error("result still held or word ready low after the ack");
      fail_cnt++;
    end

endmodule

bind cl_zcash cl_zcash_properties cl_zcash_props (
  .i_clk_100    (i_clk_100),
  .i_rst_n      (rst_main_n_sync),
  .i_bvalid     (o_bvalid),
  .i_bresp      (o_bresp),
  .i_bready     (i_bready),
  .i_rvalid     (o_rvalid),
  .i_rdata      (o_rdata),
  .i_rready     (i_rready),
  .i_word_ready (word_ready),
  .i_res_valid  (res_valid),
  .i_res_ack    (res_ack)
);

`default_nettype wire

// ==== verif/tb_cl_zcash.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cl_zcash import zcash_shell_pkg::*; ();

  localparam int TIMEOUT = 64;
  localparam int NUM_MSG = 5;

  logic       clk_100, rst_main_n;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  axil_strb_t wstrb;
  axil_resp_t bresp, rresp;

  logic [31:0] lcg_state;
  int          err_data, err_resp, err_word, err_flag;

  // Columns: word count, force carry out of bit 63, push while held,
  // REG_PUSH data for inner words, REG_PUSH data for the last word
  typedef struct packed {
    int         n_words;
    logic       wrap;
    logic       probe;
    axil_data_t mid_val;
    axil_data_t last_val;
  } msg_row_t;

  msg_row_t msg_tbl [NUM_MSG];

  cl_zcash i_cl_zcash (
    .i_clk_100 (clk_100), .i_rst_main_n (rst_main_n),
    .i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (awready),
    .i_wvalid  (wvalid),  .i_wdata  (wdata),  .i_wstrb   (wstrb),  .o_wready (wready),
    .o_bvalid  (bvalid),  .o_bresp  (bresp),  .i_bready  (bready),
    .i_arvalid (arvalid), .i_araddr (araddr), .o_arready (arready),
    .o_rvalid  (rvalid),  .o_rdata  (rdata),  .o_rresp   (rresp),  .i_rready (rready)
  );

  always #5 clk_100 = ~clk_100;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      err_resp++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
      err_word++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
      err_flag++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  // --------------------
  // AXI-lite driver
  // --------------------
  // Handshakes are sampled at the falling edge and take effect at the next rising edge
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold_b,
                            output axil_resp_t resp);
    int   cycles;
    int   held;
    logic aw_done, w_done, b_done;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold_b == 0);
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    while (!(aw_done && w_done)) begin
      @(negedge clk_100);
      aw_done = aw_done || (awvalid && awready);
      w_done  = w_done || (wvalid && wready);
      @(posedge clk_100);
      #1;
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
      cycles++;
      if (cycles > TIMEOUT) abort_on_timeout("write address and data ready");
    end
    b_done = 1'b0;
    held   = 0;
    cycles = 0;
    while (!b_done) begin
      @(negedge clk_100);
      if (bvalid && bready) begin
        resp   = bresp;
        b_done = 1'b1;
      end else if (bvalid) begin
        held++;
      end
      @(posedge clk_100);
      #1;
      if (held >= hold_b) bready = 1'b1;
      cycles++;
      if (cycles > TIMEOUT) abort_on_timeout("write response");
    end
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    int   cycles;
    logic ar_done, r_done;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    ar_done = 1'b0;
    cycles  = 0;
    while (!ar_done) begin
      @(negedge clk_100);
      ar_done = arready;
      @(posedge clk_100);
      #1;
      if (ar_done) arvalid = 1'b0;
      cycles++;
      if (cycles > TIMEOUT) abort_on_timeout("read address ready");
    end
    r_done = 1'b0;
    cycles = 0;
    while (!r_done) begin
      @(negedge clk_100);
      if (rvalid) begin
        data   = rdata;
        resp   = rresp;
        r_done = 1'b1;
      end
      @(posedge clk_100);
      #1;
      cycles++;
      if (cycles > TIMEOUT) abort_on_timeout("read data");
    end
  endtask

  task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
    axil_resp_t resp;
    axil_write(addr, data, 0, resp);
    check_resp($sformatf("bresp at 0x%h", addr), resp, RESP_OKAY);
  endtask

  task automatic read_expect(input axil_addr_t addr, input axil_data_t exp, input string name);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(addr, data, resp);
    check_resp({name, " rresp"}, resp, RESP_OKAY);
    check_data(name, data, exp);
  endtask

  task automatic read_sum(output word_t sum);
    axil_data_t lo, hi;
    axil_resp_t resp;
    axil_read(REG_SUM_LO, lo, resp);
    check_resp("sum_lo rresp", resp, RESP_OKAY);
    axil_read(REG_SUM_HI, hi, resp);
    check_resp("sum_hi rresp", resp, RESP_OKAY);
    sum = {hi, lo};
  endtask

  task automatic wait_result();
    axil_data_t status;
    axil_resp_t resp;
    int         polls;
    status = '0;
    polls  = 0;
    while (!status[0]) begin
      axil_read(REG_STATUS, status, resp);
      polls++;
      if (polls > TIMEOUT) abort_on_timeout("result valid in status");
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    msg_row_t   row;
    word_t      w, exp_sum, sum;
    axil_data_t rd;
    axil_resp_t resp;
    int         total;
    clk_100    = 1'b0;
    rst_main_n = 1'b0;
    {awvalid, wvalid, arvalid} = '0;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    wstrb      = '0;
    bready     = 1'b1;
    rready     = 1'b1;
    lcg_state  = 32'd23;
    err_data   = 0;
    err_resp   = 0;
    err_word   = 0;
    err_flag   = 0;
    msg_tbl[0] = '{1, 1'b0, 1'b1, 32'h0000_0000, 32'h0000_0001};
    msg_tbl[1] = '{3, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0001};
    msg_tbl[2] = '{4, 1'b1, 1'b1, 32'hFFFF_FFFE, 32'hFFFF_FFFF};
    msg_tbl[3] = '{2, 1'b0, 1'b0, 32'h0000_0002, 32'h0000_0003};
    msg_tbl[4] = '{6, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_0001};

    repeat (2) @(posedge clk_100);
    #1 rst_main_n = 1'b1;
    repeat (4) @(posedge clk_100);
    #1;

    // Idle handshake state out of reset
    check_flag("awready after reset", awready, 1'b1);
    check_flag("wready after reset", wready, 1'b1);
    check_flag("arready after reset", arready, 1'b1);
    check_flag("bvalid after reset", bvalid, 1'b0);
    check_flag("rvalid after reset", rvalid, 1'b0);

    read_expect(REG_STATUS, 32'h2, "status after reset");

    for (int m = 0; m < NUM_MSG; m++) begin
      row     = msg_tbl[m];
      exp_sum = '0;
      for (int i = 0; i < row.n_words; i++) begin
        w[63:32] = lcg_next();
        w[31:0]  = lcg_next();
        if (row.wrap) w[WORD_W-1 -: 4] = 4'hF;
        exp_sum = exp_sum + w;
        write_ok(REG_DATA_LO, w[31:0]);
        write_ok(REG_DATA_HI, w[63:32]);
        write_ok(REG_PUSH, (i == row.n_words - 1) ? row.last_val : row.mid_val);
      end
      wait_result();
      read_sum(sum);
      check_word("result sum", sum, exp_sum);
      read_expect(REG_COUNT, axil_data_t'(row.n_words), "result count");
      if (row.probe) begin
        axil_write(REG_PUSH, 32'h1, 0, resp);
        check_resp("bresp push while held", resp, RESP_SLVERR);
        read_sum(sum);
        check_word("held sum", sum, exp_sum);
      end
      write_ok(REG_ACK, 32'h1);
      read_expect(REG_STATUS, 32'h2, "status after ack");
    end

    // Unmapped addresses
    axil_read(32'h0000_0040, rd, resp);
    check_resp("rresp unmapped", resp, RESP_DECERR);
    check_data("rdata unmapped", rd, 32'h0);
    axil_write(32'h0000_0044, 32'h1234_5678, 0, resp);
    check_resp("bresp unmapped", resp, RESP_DECERR);

    // Ack with nothing held
    write_ok(REG_ACK, 32'h1);
    read_expect(REG_STATUS, 32'h2, "status after idle ack");

    // Back-pressure on the write response
    axil_write(REG_DATA_LO, 32'hA5A5_5A5A, 4, resp);
    check_resp("bresp under back-pressure", resp, RESP_OKAY);
    read_expect(REG_DATA_LO, 32'hA5A5_5A5A, "data_lo after held response");

    total = err_data + err_resp + err_word + err_flag + i_cl_zcash.cl_zcash_props.fail_cnt;
    $display("Errors: data %0d, resp %0d, word %0d, flag %0d, assertions %0d",
             err_data, err_resp, err_word, err_flag, i_cl_zcash.cl_zcash_props.fail_cnt);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/zcash_shell_pkg.sv
source/axi_skid.sv
source/axil_reg_slice.sv
source/zcash_bridge.sv
source/zcash_digest_core.sv
source/cl_zcash.sv
verif/cl_zcash_properties.sv
verif/tb_cl_zcash.sv

// ==== Makefile ====
TOP := tb_cl_zcash

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

# Status comes from the search for the pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
